/* hdl/icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_sets       = 128;
    localparam int num_ways       = 2;
    localparam int set_w          = 7;
    localparam int tag_w          = 20;
    localparam int beat_w         = 32;
    localparam int beats_per_line = 8;
    localparam int fetch_w        = 128;

    // id the memory side returns for our bursts
    localparam logic [3:0] icache_rid = 4'd0;

    typedef logic [set_w-1:0]   set_t;
    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [fetch_w-1:0] fetch_t;

    // refill writes by beat, lookup picks a half
    typedef union packed {
        logic [beats_per_line-1:0][beat_w-1:0] beat;
        logic [1:0][fetch_w-1:0]               half;
    } line_t;

    ////////////////////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_reset,
        st_idle,
        st_run,
        st_miss,
        st_refill,
        st_finish,
        st_recover
    } state_t;

endpackage

/* hdl/fill_if.sv */
`timescale 1ns/1ps

interface fill_if;
    import icache_pkg::*;

    // request side, from the controller
    logic  start;
    set_t  set;
    tag_t  tag;
    logic  half;
    logic  finish;

    // refill buffer state
    logic  done;
    logic  hit_fill;
    line_t fill_line;
    set_t  fill_set;
    tag_t  fill_tag;

    modport ctrl (output start, set, tag, half, finish, input done);
    modport refill (
        input  start, set, tag, half, finish,
        output done, hit_fill, fill_line, fill_set, fill_tag
    );
    modport lookup (input hit_fill, fill_line, fill_set, fill_tag);

endinterface

/* hdl/icache_tag_ram.sv */
`timescale 1ns/1ps

module icache_tag_ram #(
    parameter int DEPTH = 128
) (
    input  logic               clk,
    input  icache_pkg::set_t   set,
    input  logic               tag_wen,
    input  logic               val_wen,
    input  icache_pkg::tag_t   wtag,
    input  logic               wvalid,
    output icache_pkg::tag_t   rtag,
    output logic               rvalid
);
    import icache_pkg::*;

    tag_t tag_mem [DEPTH];
    logic val_mem [DEPTH];

    // tag and valid written separately, sweep only touches valid
    always_ff @(posedge clk) begin
        if (tag_wen) begin
            tag_mem[set] <= wtag;
        end
        if (val_wen) begin
            val_mem[set] <= wvalid;
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        rtag   <= tag_mem[set];
        rvalid <= val_mem[set];
    end

endmodule

/* hdl/icache_data_ram.sv */
`timescale 1ns/1ps

module icache_data_ram #(
    parameter int DEPTH = 128
) (
    input  logic              clk,
    input  icache_pkg::set_t  set,
    input  logic              wen,
    input  icache_pkg::line_t wline,
    output icache_pkg::line_t rline
);
    import icache_pkg::*;

    line_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[set] <= wline;
        end
    end

    // one cycle read
    always_ff @(posedge clk) begin
        rline <= mem[set];
    end

endmodule

/* hdl/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill (
    input  logic        clk,
    input  logic        rst,
    fill_if.refill      fill,
    output logic        arvalid,
    output logic [31:0] araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        arready,
    input  logic [3:0]  rid,
    input  logic [31:0] rdata_bus,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);
    import icache_pkg::*;

    localparam int cnt_w  = $clog2(beats_per_line);
    localparam int half_n = beats_per_line / 2;

    logic                      ar_pend;
    logic                      busy;
    logic                      beat;
    logic [cnt_w-1:0]          cnt;
    logic [beats_per_line-1:0] beat_valid;
    logic [half_n-1:0]         half_valid;
    line_t                     buf_line;
    set_t                      set_q;
    tag_t                      tag_q;

    ////////////////////////////////////////////////////////////////////////////
    // read address channel
    ////////////////////////////////////////////////////////////////////////////

    // start is the first miss cycle, so arvalid covers the whole miss state
    assign arvalid = fill.start || ar_pend;
    assign araddr  = {fill.tag, fill.set, fill.half, 4'b0000};
    assign arlen   = 4'(beats_per_line - 1);
    assign arsize  = 3'($clog2(beat_w / 8));
    // wrap, critical word first
    assign arburst = 2'b10;

    ////////////////////////////////////////////////////////////////////////////
    // read data channel
    ////////////////////////////////////////////////////////////////////////////

    assign rready = busy;
    assign beat   = busy && rvalid && (rid == icache_rid);

    always_ff @(posedge clk) begin
        if (!rst) begin
            ar_pend    <= 1'b0;
            busy       <= 1'b0;
            fill.done  <= 1'b0;
            cnt        <= '0;
            beat_valid <= '0;
        end else begin
            if (arvalid && arready) begin
                ar_pend <= 1'b0;
            end else if (fill.start) begin
                ar_pend <= 1'b1;
            end
            if (arvalid && arready) begin
                busy <= 1'b1;
            end else if (fill.done) begin
                busy <= 1'b0;
            end
            fill.done <= beat && rlast;
            // counter wraps inside the line like the burst does
            if (fill.start) begin
                cnt <= {fill.half, {(cnt_w - 1){1'b0}}};
            end else if (beat) begin
                cnt <= cnt + 1'b1;
            end
            if (fill.finish) begin
                beat_valid <= '0;
            end else if (beat) begin
                beat_valid[cnt] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.start) begin
            set_q <= fill.set;
            tag_q <= fill.tag;
        end
        if (beat) begin
            buf_line.beat[cnt] <= rdata_bus;
        end
    end

    // hit under refill once the requested half is in
    assign half_valid    = beat_valid[{fill.half, {(cnt_w - 1){1'b0}}} +: half_n];
    assign fill.hit_fill = (set_q == fill.set) && (tag_q == fill.tag) && (&half_valid);

    assign fill.fill_line = buf_line;
    assign fill.fill_set  = set_q;
    assign fill.fill_tag  = tag_q;

endmodule

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    fill_if.ctrl                 fill,
    input  logic                 miss_req,
    input  icache_pkg::set_t     miss_set,
    input  icache_pkg::tag_t     miss_tag,
    input  logic                 miss_half,
    input  logic                 arready,
    output icache_pkg::state_t   state,
    output icache_pkg::set_t     sweep_set,
    output logic [1:0]           victim
);
    import icache_pkg::*;

    state_t state_nx;
    logic   plru [num_sets];

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            st_reset: begin
                if (sweep_set == set_t'(num_sets - 1)) begin
                    state_nx = st_idle;
                end
            end
            st_idle:    state_nx = st_run;
            st_run: begin
                if (miss_req) begin
                    state_nx = st_miss;
                end
            end
            st_miss: begin
                if (arready) begin
                    state_nx = st_refill;
                end
            end
            st_refill: begin
                if (fill.done) begin
                    state_nx = st_finish;
                end
            end
            // finish writes, recover rereads the held set, idle the tag stage
            st_finish:  state_nx = st_recover;
            st_recover: state_nx = st_idle;
            default:    state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= st_reset;
            sweep_set  <= '0;
            fill.start <= 1'b0;
        end else begin
            state      <= state_nx;
            fill.start <= (state == st_run) && miss_req;
            if (state == st_reset) begin
                sweep_set <= sweep_set + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pseudo-LRU
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= 2'b00;
            for (int i = 0; i < num_sets; i++) begin
                plru[i] <= 1'b0;
            end
        end else begin
            if ((state == st_run) && miss_req) begin
                victim <= plru[miss_set] ? 2'b10 : 2'b01;
            end
            // point away from the way just filled
            if (state == st_miss) begin
                plru[miss_set] <= victim[0];
            end
        end
    end

    assign fill.set    = miss_set;
    assign fill.tag    = miss_tag;
    assign fill.half   = miss_half;
    assign fill.finish = (state == st_finish);

endmodule

/* hdl/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic [7:0]              index,
    input  icache_pkg::tag_t        tag,
    output logic                    index_ok,
    output logic                    data_ok,
    output icache_pkg::fetch_t      rdata,
    fill_if.lookup                  fill,
    input  icache_pkg::state_t      state,
    input  icache_pkg::set_t        sweep_set,
    input  logic [1:0]              victim,
    output icache_pkg::set_t        ram_set,
    output logic [1:0]              tag_wen,
    output logic [1:0]              val_wen,
    output icache_pkg::tag_t        wtag,
    output logic                    wvalid,
    input  icache_pkg::tag_t [1:0]  rtag,
    input  logic [1:0]              rvalid,
    output logic [1:0]              data_wen,
    output icache_pkg::line_t       wline,
    input  icache_pkg::line_t [1:0] rline,
    output logic                    miss_req,
    output icache_pkg::set_t        miss_set,
    output icache_pkg::tag_t        miss_tag,
    output logic                    miss_half
);
    import icache_pkg::*;

    set_t                  sin_set;
    logic                  sin_half;
    logic                  sta_req;
    logic                  sta_fresh;
    logic                  sta_half;
    set_t                  sta_set;
    tag_t                  sta_tag;
    tag_t                  sta_tag_q;
    logic                  sda_req;
    logic                  sda_half;
    set_t                  sda_set;
    tag_t                  sda_tag;
    tag_t [num_ways-1:0]   sda_rtag;
    logic [num_ways-1:0]   sda_valid;
    line_t [num_ways-1:0]  sda_line;
    logic [num_ways-1:0]   hit_way;
    logic                  hit_run;
    logic                  sda_adv;

    assign sin_set  = index[7:1];
    assign sin_half = index[0];

    assign sda_adv  = !sda_req || data_ok;
    assign index_ok = req && (state == st_run) && sda_adv;

    // tag is on the bus only in the first tag-stage cycle
    assign sta_tag = sta_fresh ? tag : sta_tag_q;

    ////////////////////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            sta_req   <= 1'b0;
            sta_fresh <= 1'b0;
            sda_req   <= 1'b0;
        end else begin
            sta_fresh <= index_ok;
            if (sda_adv) begin
                sta_req <= index_ok;
                sda_req <= sta_req;
            end
        end
    end

    always_ff @(posedge clk) begin
        sta_tag_q <= sta_tag;
        if (index_ok) begin
            sta_set  <= sin_set;
            sta_half <= sin_half;
        end
        if (sda_adv) begin
            sda_set  <= sta_set;
            sda_half <= sta_half;
            sda_tag  <= sta_tag;
        end
        // idle picks up the line reread after a refill
        if (sda_adv || (state == st_idle)) begin
            sda_rtag  <= rtag;
            sda_valid <= rvalid;
            sda_line  <= rline;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // array port
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            st_reset:  ram_set = sweep_set;
            st_finish: ram_set = fill.fill_set;
            st_run:    ram_set = sin_set;
            st_idle:   ram_set = sta_set;
            default:   ram_set = sda_set;
        endcase
    end

    assign tag_wen  = (state == st_finish) ? victim : 2'b00;
    assign val_wen  = (state == st_reset) ? '1 : tag_wen;
    assign wtag     = fill.fill_tag;
    assign wvalid   = (state == st_finish);
    assign data_wen = tag_wen;
    assign wline    = fill.fill_line;

    ////////////////////////////////////////////////////////////////////////////
    // compare and select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = sda_valid[w] && (sda_rtag[w] == sda_tag);
        end
    end

    assign hit_run = (|hit_way) && (state == st_run);
    assign data_ok = sda_req && (hit_run || fill.hit_fill);
    assign rdata   = fill.hit_fill ? fill.fill_line.half[sda_half]
                                   : sda_line[hit_way[1]].half[sda_half];

    assign miss_req  = (state == st_run) && sda_req && !hit_run;
    assign miss_set  = sda_set;
    assign miss_tag  = sda_tag;
    assign miss_half = sda_half;

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ps

module icache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  logic [7:0]          index,
    input  icache_pkg::tag_t    tag,
    output logic                index_ok,
    output logic                data_ok,
    output icache_pkg::fetch_t  rdata,
    output logic                arvalid,
    output logic [31:0]         araddr,
    output logic [3:0]          arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    input  logic                arready,
    input  logic [3:0]          rid,
    input  logic [31:0]         rdata_bus,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);
    import icache_pkg::*;

    state_t               state;
    set_t                 sweep_set;
    logic [1:0]           victim;
    logic                 miss_req;
    set_t                 miss_set;
    tag_t                 miss_tag;
    logic                 miss_half;
    set_t                 ram_set;
    logic [1:0]           tag_wen;
    logic [1:0]           val_wen;
    tag_t                 wtag;
    logic                 wvalid;
    tag_t [1:0]           rtag;
    logic [1:0]           tv_valid;
    logic [1:0]           data_wen;
    line_t                wline;
    line_t [1:0]          rline;

    fill_if fill0 ();

    icache_ctrl ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .fill      (fill0.ctrl),
        .miss_req  (miss_req),
        .miss_set  (miss_set),
        .miss_tag  (miss_tag),
        .miss_half (miss_half),
        .arready   (arready),
        .state     (state),
        .sweep_set (sweep_set),
        .victim    (victim)
    );

    icache_refill refill0 (
        .clk       (clk),
        .rst       (rst),
        .fill      (fill0.refill),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arready   (arready),
        .rid       (rid),
        .rdata_bus (rdata_bus),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    icache_lookup lookup0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .index     (index),
        .tag       (tag),
        .index_ok  (index_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .fill      (fill0.lookup),
        .state     (state),
        .sweep_set (sweep_set),
        .victim    (victim),
        .ram_set   (ram_set),
        .tag_wen   (tag_wen),
        .val_wen   (val_wen),
        .wtag      (wtag),
        .wvalid    (wvalid),
        .rtag      (rtag),
        .rvalid    (tv_valid),
        .data_wen  (data_wen),
        .wline     (wline),
        .rline     (rline),
        .miss_req  (miss_req),
        .miss_set  (miss_set),
        .miss_tag  (miss_tag),
        .miss_half (miss_half)
    );

    // one tag array and one data array per way
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        icache_tag_ram #(.DEPTH(num_sets)) tag_ram0 (
            .clk     (clk),
            .set     (ram_set),
            .tag_wen (tag_wen[w]),
            .val_wen (val_wen[w]),
            .wtag    (wtag),
            .wvalid  (wvalid),
            .rtag    (rtag[w]),
            .rvalid  (tv_valid[w])
        );

        icache_data_ram #(.DEPTH(num_sets)) data_ram0 (
            .clk   (clk),
            .set   (ram_set),
            .wen   (data_wen[w]),
            .wline (wline),
            .rline (rline[w])
        );
    end

endmodule

/* dv/icache_assertions.sv */
`timescale 1ns/1ps

module icache_assertions (
    input logic               clk,
    input logic               rst,
    input logic               index_ok,
    input logic               data_ok,
    input icache_pkg::fetch_t rdata,
    input logic               arvalid,
    input logic [31:0]        araddr,
    input logic               arready
);

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("read address dropped before arready");

    a_rdata_known: assert property (@(posedge clk) disable iff (!rst)
        data_ok |-> !$isunknown(rdata))
        else $error("rdata unknown at data_ok");

    // quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst |=> !index_ok && !data_ok && !arvalid)
        else $error("outputs active after reset");

endmodule

/* dv/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int max_tests    = 64;
    localparam int sweep_cycles = num_sets + 1;

    logic               clk;
    logic               rst;
    logic               req;
    logic [7:0]         index;
    tag_t               tag;
    logic               index_ok;
    logic               data_ok;
    fetch_t             rdata;
    logic               arvalid;
    logic [31:0]        araddr;
    logic [3:0]         arlen;
    logic [2:0]         arsize;
    logic [1:0]         arburst;
    logic               arready;
    logic [3:0]         rid;
    logic [31:0]        rdata_bus;
    logic               rlast;
    logic               rvalid;
    logic               rready;

    // four words per test: index, tag, miss, back-to-back
    logic [31:0] tests [0:4*max_tests-1];
    int          n_tests;
    bit          loaded;
    bit          running;
    int          cyc;
    int          n_hs;
    int          n_done;
    int          hs_cyc [max_tests];
    int          last_done;
    bit          ar_seen;
    integer      seed;

    icache_top dut0 (.*);

    bind icache_top icache_assertions assert0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting and compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("ERR %0t: %s", $time, msg));
    endtask

    task automatic check_fetch(input fetch_t got, input fetch_t exp, input int k);
        if (got !== exp) begin
            report_error($sformatf("test %0d rdata %h, expected %h", k, got, exp));
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input int k);
        if (got !== exp) begin
            report_error($sformatf("test %0d araddr %h, expected %h", k, got, exp));
        end
    endtask

    task automatic check_miss(input bit got, input bit exp, input int k);
        if (got !== exp) begin
            report_error($sformatf("test %0d miss %0b, expected %0b", k, got, exp));
        end
    endtask

    // half address built from the request fields
    function automatic logic [31:0] half_addr(input int k);
        return {tests[4*k+1][19:0], tests[4*k][7:0], 4'b0000};
    endfunction

    // memory rule: each word is its address xor a fixed pattern
    function automatic fetch_t expected_fetch(input int k);
        logic [31:0] base;
        fetch_t      f;
        int          j;
        base = half_addr(k);
        for (j = 0; j < 4; j++) begin
            f[32*j +: 32] = (base + 32'(4 * j)) ^ 32'h5a5a5a5a;
        end
        return f;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // AXI read memory model
    ////////////////////////////////////////////////////////////////////////////

    initial begin : memory_model
        logic [31:0] base;
        int          gap;
        int          i;
        seed = 32'h3bd30f0e;
        forever begin
            @(posedge clk);
            #1;
            if (rst && arvalid) begin
                // address channel may wait a few cycles
                gap = {$random(seed)} % 3;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                base    = araddr;
                arready = 1'b1;
                @(posedge clk);
                #1;
                arready = 1'b0;
                for (i = 0; i < beats_per_line; i++) begin
                    gap = {$random(seed)} % 4;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    rvalid    = 1'b1;
                    rid       = icache_rid;
                    rlast     = (i == beats_per_line - 1);
                    // wrap inside the 32-byte line
                    rdata_bus = {base[31:5], 5'(base[4:0] + 5'(4 * i))} ^ 32'h5a5a5a5a;
                    @(negedge clk);
                    if (!rready) begin
                        stop_run("rready was low while a burst beat was offered");
                    end
                    @(posedge clk);
                    #1;
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(negedge clk) begin : monitor
        int k;
        if (running && rst) begin
            if (cyc < sweep_cycles && (index_ok || arvalid || data_ok)) begin
                stop_run("the cache answered before the reset sweep had ended");
            end
            if (arvalid && !ar_seen) begin
                check_addr(araddr, half_addr(n_done), n_done);
                // eight beats of four bytes, wrap burst
                if (arlen !== 4'd7 || arsize !== 3'd2 || arburst !== 2'b10) begin
                    report_error($sformatf("arlen %0d arsize %0d arburst %0b",
                                           arlen, arsize, arburst));
                end
                ar_seen = 1'b1;
            end
            if (req && index_ok) begin
                hs_cyc[n_hs] = cyc;
                n_hs++;
            end
            if (data_ok) begin
                k = n_done;
                if (k >= n_hs) begin
                    stop_run("data_ok came with no request outstanding");
                end
                check_fetch(rdata, expected_fetch(k), k);
                check_miss(ar_seen, tests[4*k+2][0], k);
                if (!tests[4*k+2][0] && cyc - hs_cyc[k] != 2) begin
                    report_error($sformatf("test %0d hit latency %0d", k, cyc - hs_cyc[k]));
                end
                if (k > 0 && tests[4*(k-1)+3][0] && cyc != last_done + 1) begin
                    report_error($sformatf("test %0d data_ok not back-to-back", k));
                end
                ar_seen   = 1'b0;
                last_done = cyc;
                n_done++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int k;
        rst       = 1'b0;
        req       = 1'b0;
        index     = '0;
        tag       = '0;
        arready   = 1'b0;
        rid       = '0;
        rdata_bus = '0;
        rlast     = 1'b0;
        rvalid    = 1'b0;
        cyc       = 0;
        n_hs      = 0;
        n_done    = 0;
        last_done = 0;
        ar_seen   = 1'b0;
        running   = 1'b0;
        loaded    = 1'b0;
        $readmemh("dv/icache_tests.txt", tests);
        n_tests = 0;
        while (n_tests < max_tests && tests[4*n_tests] !== 32'hffffffff) begin
            n_tests++;
        end
        loaded = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        rst     = 1'b1;
        cyc     = 0;
        running = 1'b1;

        for (k = 0; k < n_tests; k++) begin
            req   = 1'b1;
            index = tests[4*k][7:0];
            while (n_hs <= k) begin
                @(posedge clk);
                #1;
            end
            // tag cycle
            tag = tests[4*k+1][19:0];
            req = 1'b0;
            if (!(tests[4*k+3][0] && k + 1 < n_tests)) begin
                while (n_done <= k) begin
                    @(posedge clk);
                    #1;
                end
            end
        end

        repeat (2) @(posedge clk);
        if (n_done == n_tests && n_tests > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_run($sformatf("only %0d of %0d fetches completed", n_done, n_tests));
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (400 * n_tests + 2 * sweep_cycles) @(posedge clk);
        stop_run("watchdog expired before all fetches completed");
    end

endmodule

/* dv/icache_tests.txt */
// columns: index (set and half), tag, expected miss, back-to-back with next
// a row of all ffffffff ends the list
0a 12345 1 0
0b 12345 0 0
0a 12345 0 1
0b 12345 0 0
41 abcde 1 0
41 abcde 0 1
0a 12345 0 1
41 abcde 0 0
// three tags on set 33
66 11111 1 0
66 22222 1 0
67 33333 1 0
66 22222 0 0
67 11111 1 0
66 33333 0 0
67 11111 0 1
66 33333 0 0
66 22222 1 0
// edge sets
ff 0fedc 1 0
fe 0fedc 0 0
00 00000 1 0
01 00000 0 1
00 00000 0 0
ffffffff ffffffff ffffffff ffffffff

/* build.f */
hdl/icache_pkg.sv
hdl/fill_if.sv
hdl/icache_tag_ram.sv
hdl/icache_data_ram.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/icache_lookup.sv
hdl/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv
